// File: hdl/adc_capture_top.sv
module adc_capture_top #(
	parameter int addr_width = 15,
	parameter int fifo_depth = 4
) (
	input  logic                       adc_clkinp,
	input  logic                       reset,

	// deserialized frames from the ADC
	input  adc_frame_pkg::raw_frame_t  frame_data,
	input  logic                       frame_valid,
	output logic                       frame_ready,

	// capture control, stable during a capture
	input  logic                       start,
	input  logic                       state_reset,
	input  logic [addr_width-1:0]      rec_length,
	input  logic [3:0]                 down_sample,
	input  ram_word_pkg::sample_mode_e sample_mode,
	input  ram_word_pkg::pack_mode_e   pack_mode,

	output logic                       capture_busy,
	output logic                       done_irq,

	// sample RAM write port
	output logic                       ram_wren,
	output logic [addr_width-1:0]      ram_addr,
	output ram_word_pkg::ram_word_u    ram_data
);

	adc_frame_pkg::lane_frame_t dec_data;
	logic                       dec_valid;
	logic                       dec_ready;
	adc_frame_pkg::lane_frame_t pk_data;
	logic                       pk_valid;
	logic                       pk_ready;
	logic                       armed;

	frame_decimator decim_i (
		.adc_clkinp  (adc_clkinp),
		.reset       (reset),
		.frame_data  (frame_data),
		.frame_valid (frame_valid),
		.frame_ready (frame_ready),
		.armed       (armed),
		.down_sample (down_sample),
		.sample_mode (sample_mode),
		.dec_data    (dec_data),
		.dec_valid   (dec_valid),
		.dec_ready   (dec_ready)
	);

	// soaks up group bursts and the drain after the last word
	frame_fifo #(
		.fifo_depth (fifo_depth)
	) fifo_i (
		.adc_clkinp (adc_clkinp),
		.reset      (reset),
		.in_data    (dec_data),
		.in_valid   (dec_valid),
		.in_ready   (dec_ready),
		.out_data   (pk_data),
		.out_valid  (pk_valid),
		.out_ready  (pk_ready)
	);

	ram_word_packer #(
		.addr_width (addr_width)
	) packer_i (
		.adc_clkinp   (adc_clkinp),
		.reset        (reset),
		.start        (start),
		.state_reset  (state_reset),
		.rec_length   (rec_length),
		.pack_mode    (pack_mode),
		.pk_data      (pk_data),
		.pk_valid     (pk_valid),
		.pk_ready     (pk_ready),
		.armed        (armed),
		.capture_busy (capture_busy),
		.done_irq     (done_irq),
		.ram_wren     (ram_wren),
		.ram_addr     (ram_addr),
		.ram_data     (ram_data)
	);

endmodule

// File: hdl/adc_frame_pkg.sv
package adc_frame_pkg;

	// one frame carries a sample from every ADC channel
	localparam int num_channels = 8;
	localparam int sample_width = 12;  // ADC resolution
	localparam int lane_width   = 16;  // room for group sums

	// deserialized input frame, channel 0 in the low bits
	typedef logic [num_channels-1:0][sample_width-1:0] raw_frame_t;

	// widened frame between decimator, FIFO and packer
	typedef logic [num_channels-1:0][lane_width-1:0] lane_frame_t;

endpackage

// File: hdl/frame_decimator.sv
module frame_decimator (
	input  logic                       adc_clkinp,
	input  logic                       reset,
	input  adc_frame_pkg::raw_frame_t  frame_data,
	input  logic                       frame_valid,
	output logic                       frame_ready,
	input  logic                       armed,
	input  logic [3:0]                 down_sample,
	input  ram_word_pkg::sample_mode_e sample_mode,
	output adc_frame_pkg::lane_frame_t dec_data,
	output logic                       dec_valid,
	input  logic                       dec_ready
);

	localparam int pad_width = adc_frame_pkg::lane_width - adc_frame_pkg::sample_width;

	logic                       ready_en;   // held low through reset
	logic [3:0]                 group_cnt;  // frames accepted in current group
	adc_frame_pkg::lane_frame_t widened;
	adc_frame_pkg::lane_frame_t sum;
	adc_frame_pkg::lane_frame_t acc;        // running sum of the group so far
	logic                       accept;
	logic                       group_end;

	// zero-extend each sample and add it to the running sum
	always_comb
	begin
		for (int i = 0; i < adc_frame_pkg::num_channels; i++)
		begin
			widened[i] = {{pad_width{1'b0}}, frame_data[i]};
			sum[i]     = acc[i] + widened[i];  // wraps at 16 bits
		end
	end

	// stall the source only while a finished group still waits for the FIFO
	assign frame_ready = ready_en & (~armed | ~dec_valid | dec_ready);
	assign accept      = frame_valid & frame_ready & armed;
	assign group_end   = accept & (group_cnt == down_sample);

	always_ff @(posedge adc_clkinp)
	begin
		if (reset)
		begin
			ready_en  <= 1'b0;
			group_cnt <= '0;
			dec_valid <= 1'b0;
		end
		else
		begin
			ready_en <= 1'b1;

			// idle frames are dropped, the group restarts once armed
			if (!armed)
			begin
				group_cnt <= '0;
			end
			else if (accept)
			begin
				group_cnt <= group_end ? 4'd0 : group_cnt + 4'd1;
			end

			if (dec_valid && dec_ready)
				dec_valid <= 1'b0;
			if (group_end)
				dec_valid <= 1'b1;  // new result wins over the handshake
		end
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (!armed || group_end)
			acc <= '0;
		else if (accept)
			acc <= sum;

		// output register, held until the FIFO takes it
		if (group_end)
		begin
			if (sample_mode == ram_word_pkg::group_sum)
				dec_data <= sum;
			else
				dec_data <= widened;
		end
	end

endmodule

// File: hdl/frame_fifo.sv
module frame_fifo #(
	parameter int fifo_depth = 4
) (
	input  logic                       adc_clkinp,
	input  logic                       reset,
	input  adc_frame_pkg::lane_frame_t in_data,
	input  logic                       in_valid,
	output logic                       in_ready,
	output adc_frame_pkg::lane_frame_t out_data,
	output logic                       out_valid,
	input  logic                       out_ready
);

	localparam int ptr_width = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int cnt_width = $clog2(fifo_depth + 1);

	adc_frame_pkg::lane_frame_t mem [fifo_depth];
	logic [ptr_width-1:0]       wr_ptr;
	logic [ptr_width-1:0]       rd_ptr;
	logic [cnt_width-1:0]       count;   // items held
	logic                       push;
	logic                       pop;

	// pointer step with wrap, depth need not be a power of two
	function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
		if (ptr == ptr_width'(fifo_depth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign in_ready  = (count != cnt_width'(fifo_depth));
	assign out_valid = (count != '0);
	assign out_data  = mem[rd_ptr];  // head is visible the cycle after its write
	assign push      = in_valid & in_ready;
	assign pop       = out_valid & out_ready;

	always_ff @(posedge adc_clkinp)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);

			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // both or neither
			endcase
		end
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

endmodule

// File: hdl/ram_word_packer.sv
module ram_word_packer #(
	parameter int addr_width = 15
) (
	input  logic                       adc_clkinp,
	input  logic                       reset,
	input  logic                       start,
	input  logic                       state_reset,
	input  logic [addr_width-1:0]      rec_length,
	input  ram_word_pkg::pack_mode_e   pack_mode,
	input  adc_frame_pkg::lane_frame_t pk_data,
	input  logic                       pk_valid,
	output logic                       pk_ready,
	output logic                       armed,
	output logic                       capture_busy,
	output logic                       done_irq,
	output logic                       ram_wren,
	output logic [addr_width-1:0]      ram_addr,
	output ram_word_pkg::ram_word_u    ram_data
);

	localparam int smp_w      = adc_frame_pkg::sample_width;
	localparam int frame_bits = adc_frame_pkg::num_channels * smp_w;

	logic [addr_width-1:0] waddr;      // next address to write
	logic [1:0]            phase;      // frame position in a group of four
	logic [frame_bits-1:0] trimmed;    // item cut back to 12-bit samples
	logic [frame_bits-1:0] carry;      // stream bits not yet written
	logic                  take;
	logic                  writes;     // taken item completes a word
	logic                  last_word;
	logic                  finished;

	always_comb
	begin
		for (int i = 0; i < adc_frame_pkg::num_channels; i++)
			trimmed[i*smp_w +: smp_w] = pk_data[i][smp_w-1:0];
	end

	assign pk_ready  = 1'b1;  // items outside a capture are drained
	assign take      = pk_valid & armed;
	assign writes    = take & ((pack_mode == ram_word_pkg::lanes) | (phase != 2'd0));
	assign last_word = (waddr == rec_length - addr_width'(1));
	assign finished  = ram_wren & capture_busy & (ram_addr == rec_length - addr_width'(1));

	always_ff @(posedge adc_clkinp)
	begin
		if (reset || state_reset)
		begin
			armed        <= 1'b0;
			capture_busy <= 1'b0;
			done_irq     <= 1'b0;
			ram_wren     <= 1'b0;
			waddr        <= '0;
			phase        <= '0;
		end
		else
		begin
			ram_wren <= writes;

			if (start && !capture_busy)
			begin
				// trigger, new record from address 0
				armed        <= 1'b1;
				capture_busy <= 1'b1;
				done_irq     <= 1'b0;
				waddr        <= '0;
				phase        <= '0;
			end
			else
			begin
				if (take && pack_mode == ram_word_pkg::packed12)
					phase <= phase + 2'd1;

				if (writes)
				begin
					waddr <= waddr + addr_width'(1);
					if (last_word)
						armed <= 1'b0;  // record full, stop taking items
				end

				// edge after the final write
				if (finished)
				begin
					capture_busy <= 1'b0;
					done_irq     <= 1'b1;
				end
			end
		end
	end

	// 4 frames of 96 bits fill 3 words, first frame in the low bits
	always_ff @(posedge adc_clkinp)
	begin
		if (writes)
			ram_addr <= waddr;

		if (take)
		begin
			if (pack_mode == ram_word_pkg::lanes)
			begin
				ram_data.lane <= pk_data;
			end
			else
			begin
				case (phase)
					2'd0:
					begin
						carry <= trimmed;  // no write yet
					end
					2'd1:
					begin
						ram_data.flat <= {trimmed[31:0], carry};
						carry         <= {32'b0, trimmed[95:32]};
					end
					2'd2:
					begin
						ram_data.flat <= {trimmed[63:0], carry[63:0]};
						carry         <= {64'b0, trimmed[95:64]};
					end
					default:
					begin
						ram_data.flat <= {trimmed, carry[31:0]};
					end
				endcase
			end
		end
	end

endmodule

// File: hdl/ram_word_pkg.sv
package ram_word_pkg;

	localparam int ram_data_width = 128;
	localparam int ram_lane_width = 16;
	localparam int ram_lanes      = ram_data_width / ram_lane_width;

	// one RAM word, read as lanes in raw mode or as a stream slice when packed
	typedef union packed {
		logic [ram_lanes-1:0][ram_lane_width-1:0] lane;
		logic [ram_data_width-1:0]                flat;
	} ram_word_u;

	// what a decimation group leaves behind
	typedef enum logic {
		pick_last = 1'b0,  // last frame of the group
		group_sum = 1'b1   // per-channel sum, not divided
	} sample_mode_e;

	// how results are laid out in RAM
	typedef enum logic {
		lanes    = 1'b0,  // eight 16-bit lanes per word
		packed12 = 1'b1   // continuous 12-bit stream, 4 frames in 3 words
	} pack_mode_e;

endpackage

// File: run_sim.sh
#!/bin/sh
# build and run the ADC capture testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_adc_capture -f src.f \
	--Mdir obj_dir -o tb_adc_capture

./obj_dir/tb_adc_capture > sim.log 2>&1 || true
cat sim.log

if grep -qx "TB PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: src.f
+incdir+tests
hdl/adc_frame_pkg.sv
hdl/ram_word_pkg.sv
hdl/frame_decimator.sv
hdl/frame_fifo.sv
hdl/ram_word_packer.sv
hdl/adc_capture_top.sv
tests/tb_adc_capture.sv

// File: tests/tb_adc_capture_tasks.svh
task automatic check_word(input string name, input ram_word_pkg::ram_word_u got,
                          input ram_word_pkg::ram_word_u exp);
	if (got !== exp)
	begin
		mismatch_cnt++;
		$display("mismatch %s: got %h expected %h", name, got, exp);
	end
endtask

task automatic check_addr(input string name, input logic [addr_width-1:0] got,
                          input logic [addr_width-1:0] exp);
	if (got !== exp)
	begin
		mismatch_cnt++;
		$display("mismatch %s: got %h expected %h", name, got, exp);
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp)
	begin
		mismatch_cnt++;
		$display("mismatch %s: got %h expected %h", name, got, exp);
	end
endtask

function adc_frame_pkg::raw_frame_t random_frame();
	return {$random(seed), $random(seed), $random(seed)};
endfunction

// one frame offered at a negedge, held until the DUT takes it
task automatic drive_frame(input adc_frame_pkg::raw_frame_t f, input int gap);
	frame_valid = 1'b0;
	repeat (gap) @(negedge adc_clkinp);
	frame_data  = f;
	frame_valid = 1'b1;
	while (frame_ready !== 1'b1)
		@(negedge adc_clkinp);
	@(negedge adc_clkinp);  // taken on the edge in between
	frame_valid = 1'b0;
endtask

task automatic pulse_state_reset();
	state_reset = 1'b1;
	@(negedge adc_clkinp);
	state_reset = 1'b0;
endtask

task automatic start_capture(input int rec, input int ds, input ram_word_pkg::sample_mode_e smode,
                             input ram_word_pkg::pack_mode_e pmode);
	rec_length  = addr_width'(rec);
	down_sample = 4'(ds);
	sample_mode = smode;
	pack_mode   = pmode;
	got_addrs.delete();
	got_words.delete();
	start = 1'b1;
	@(negedge adc_clkinp);
	start = 1'b0;  // armed from here on
	check_flag("capture_busy", capture_busy, 1'b1);
	check_flag("done_irq", done_irq, 1'b0);
endtask

task automatic wait_done(input int limit);
	int n;
	n = 0;
	while (done_irq !== 1'b1 && n < limit)
	begin
		@(negedge adc_clkinp);
		n++;
	end
	if (done_irq !== 1'b1)
	begin
		fail_cnt++;
		$display("error: done_irq did not rise within %0d cycles", limit);
	end
endtask

// expected words from the frames sent, one result per group of ds+1
task automatic build_expected(input int ds, input ram_word_pkg::sample_mode_e smode,
                              input ram_word_pkg::pack_mode_e pmode);
	localparam int smp_w = adc_frame_pkg::sample_width;
	localparam int frame_bits = adc_frame_pkg::num_channels * smp_w;
	localparam int word_bits = ram_word_pkg::ram_data_width;
	adc_frame_pkg::lane_frame_t acc;
	adc_frame_pkg::raw_frame_t  f;
	ram_word_pkg::ram_word_u    w;
	logic [max_frames*frame_bits-1:0] stream;
	int groups;
	groups = frames.size() / (ds + 1);
	stream = '0;
	exp_words.delete();
	for (int g = 0; g < groups; g++)
	begin
		acc = '0;
		for (int k = 0; k <= ds; k++)
		begin
			f = frames[g * (ds + 1) + k];
			for (int ch = 0; ch < adc_frame_pkg::num_channels; ch++)
			begin
				if (smode == ram_word_pkg::group_sum)
					acc[ch] = acc[ch] + 16'(f[ch]);  // wraps at 16 bits
				else
					acc[ch] = 16'(f[ch]);
			end
		end
		w.lane = acc;
		if (pmode == ram_word_pkg::lanes)
			exp_words.push_back(w);
		for (int ch = 0; ch < adc_frame_pkg::num_channels; ch++)
			stream[g * frame_bits + ch * smp_w +: smp_w] = acc[ch][smp_w-1:0];
	end
	// first frame lowest in the stream
	if (pmode == ram_word_pkg::packed12)
	begin
		for (int j = 0; j < groups * frame_bits / word_bits; j++)
		begin
			w.flat = stream[j * word_bits +: word_bits];
			exp_words.push_back(w);
		end
	end
endtask

task automatic compare_record();
	int n;
	n = (got_words.size() < exp_words.size()) ? got_words.size() : exp_words.size();
	if (got_words.size() < exp_words.size())
	begin
		fail_cnt++;
		$display("error: missing writes, expected %0d but saw %0d",
		         exp_words.size(), got_words.size());
	end
	else if (got_words.size() > exp_words.size())
	begin
		fail_cnt++;
		$display("error: extra writes, expected %0d but saw %0d",
		         exp_words.size(), got_words.size());
	end
	for (int i = 0; i < n; i++)
	begin
		check_addr($sformatf("ram_addr[%0d]", i), got_addrs[i], addr_width'(i));
		check_word($sformatf("ram_data[%0d]", i), got_words[i], exp_words[i]);
	end
endtask

task automatic capture_and_check(input int rec, input int ds,
                                 input ram_word_pkg::sample_mode_e smode,
                                 input ram_word_pkg::pack_mode_e pmode,
                                 input int nframes, input int max_gap);
	int gap;
	frames.delete();
	for (int i = 0; i < nframes; i++)
		frames.push_back(random_frame());
	start_capture(rec, ds, smode, pmode);
	foreach (frames[i])
	begin
		gap = (max_gap > 0) ? int'($unsigned($random(seed)) % (max_gap + 1)) : 0;
		drive_frame(frames[i], gap);
	end
	wait_done(nframes * 8 + 20);
	check_flag("done_irq", done_irq, 1'b1);
	check_flag("capture_busy", capture_busy, 1'b0);
	repeat (10) @(negedge adc_clkinp);  // room for a stray write
	build_expected(ds, smode, pmode);
	compare_record();
endtask

task automatic lanes_direct_test();
	capture_and_check(6, 0, ram_word_pkg::pick_last, ram_word_pkg::lanes, 6, 0);
endtask

task automatic pick_last_test();
	capture_and_check(4, 3, ram_word_pkg::pick_last, ram_word_pkg::lanes, 16, 0);
endtask

task automatic group_sum_test();
	capture_and_check(4, 2, ram_word_pkg::group_sum, ram_word_pkg::lanes, 12, 0);
endtask

task automatic packed_stream_test();
	capture_and_check(6, 0, ram_word_pkg::pick_last, ram_word_pkg::packed12, 8, 0);
endtask

task automatic gap_and_abort_test();
	int kept;
	pulse_state_reset();
	check_flag("done_irq", done_irq, 1'b0);
	capture_and_check(5, 1, ram_word_pkg::pick_last, ram_word_pkg::lanes, 10, 3);
	// abort part way through a long record
	start_capture(20, 0, ram_word_pkg::pick_last, ram_word_pkg::lanes);
	repeat (6) drive_frame(random_frame(), 1);
	repeat (3) @(negedge adc_clkinp);
	check_flag("capture_busy", capture_busy, 1'b1);  // still mid record
	pulse_state_reset();
	kept = got_words.size();
	check_flag("capture_busy", capture_busy, 1'b0);
	check_flag("done_irq", done_irq, 1'b0);
	repeat (6) drive_frame(random_frame(), 0);
	repeat (10) @(negedge adc_clkinp);
	if (got_words.size() != kept)
	begin
		fail_cnt++;
		$display("error: %0d writes seen after state_reset", got_words.size() - kept);
	end
	check_flag("capture_busy", capture_busy, 1'b0);
	check_flag("done_irq", done_irq, 1'b0);
endtask

// File: tests/tb_adc_capture.sv
module tb_adc_capture;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int addr_width = 15;
	localparam int fifo_depth = 4;
	localparam int clk_period = 8;
	localparam int max_frames = 16;  // longest record of any test
	// frames of all tests, abort test included
	localparam int total_frames = 6 + 16 + 12 + 8 + 10 + 12;

	logic                       adc_clkinp;
	logic                       reset;
	adc_frame_pkg::raw_frame_t  frame_data;
	logic                       frame_valid;
	logic                       frame_ready;
	logic                       start;
	logic                       state_reset;
	logic [addr_width-1:0]      rec_length;
	logic [3:0]                 down_sample;
	ram_word_pkg::sample_mode_e sample_mode;
	ram_word_pkg::pack_mode_e   pack_mode;
	logic                       capture_busy;
	logic                       done_irq;
	logic                       ram_wren;
	logic [addr_width-1:0]      ram_addr;
	ram_word_pkg::ram_word_u    ram_data;

	integer seed = 65;
	int     mismatch_cnt = 0;
	int     fail_cnt = 0;

	adc_frame_pkg::raw_frame_t frames[$];     // frames sent in the current capture
	ram_word_pkg::ram_word_u   exp_words[$];
	ram_word_pkg::ram_word_u   got_words[$];
	logic [addr_width-1:0]     got_addrs[$];

	adc_capture_top #(
		.addr_width (addr_width),
		.fifo_depth (fifo_depth)
	) dut_i (
		.adc_clkinp   (adc_clkinp),
		.reset        (reset),
		.frame_data   (frame_data),
		.frame_valid  (frame_valid),
		.frame_ready  (frame_ready),
		.start        (start),
		.state_reset  (state_reset),
		.rec_length   (rec_length),
		.down_sample  (down_sample),
		.sample_mode  (sample_mode),
		.pack_mode    (pack_mode),
		.capture_busy (capture_busy),
		.done_irq     (done_irq),
		.ram_wren     (ram_wren),
		.ram_addr     (ram_addr),
		.ram_data     (ram_data)
	);

	initial
	begin
		adc_clkinp = 1'b0;
		forever #(clk_period / 2) adc_clkinp = ~adc_clkinp;
	end

	// 8 cycles per frame, four times over
	initial
	begin
		#(total_frames * 8 * 4 * clk_period);
		$display("error: watchdog expired before the tests finished");
		$display("TB FAILED");
		$finish;
	end

	// RAM writes, sampled mid cycle
	always @(negedge adc_clkinp)
	begin
		if (reset === 1'b0 && ram_wren === 1'b1)
		begin
			got_addrs.push_back(ram_addr);
			got_words.push_back(ram_data);
		end
	end

	`include "tb_adc_capture_tasks.svh"

	initial
	begin
		reset       = 1'b1;
		frame_data  = '0;
		frame_valid = 1'b0;
		start       = 1'b0;
		state_reset = 1'b0;
		rec_length  = '0;
		down_sample = '0;
		sample_mode = ram_word_pkg::pick_last;
		pack_mode   = ram_word_pkg::lanes;

		repeat (10) @(negedge adc_clkinp);
		check_flag("capture_busy", capture_busy, 1'b0);
		check_flag("done_irq", done_irq, 1'b0);
		check_flag("ram_wren", ram_wren, 1'b0);
		check_flag("frame_ready", frame_ready, 1'b0);
		reset = 1'b0;
		@(negedge adc_clkinp);
		check_flag("frame_ready", frame_ready, 1'b1);  // up on first cycle out of reset

		lanes_direct_test();
		pick_last_test();
		group_sum_test();
		packed_stream_test();
		gap_and_abort_test();

		$display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
